// ==== sources.f ====
rv_pkg.sv
id_ex_if.sv
rv_fetch.sv
rv_regfile.sv
rv_decode.sv
rv_execute.sv
rv_core_top.sv
tb_clk_gen.sv
rv_core_chk.sv
rv_core_tb.sv

// ==== Bender.yml ====
package:
  name: rv_core

sources:
  - files:
      - rv_pkg.sv
      - id_ex_if.sv
      - rv_fetch.sv
      - rv_regfile.sv
      - rv_decode.sv
      - rv_execute.sv
      - rv_core_top.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - rv_core_chk.sv
      - rv_core_tb.sv

// ==== rv_core_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_tb;
  import rv_pkg::*;

  localparam int   IMEM_DEPTH    = 256;
  localparam int   STORE_TIMEOUT = 400;
  localparam int   RESET_TIMEOUT = 20;
  localparam int   HALT_WINDOW   = 200;
  localparam word_t DMEM_BASE    = 32'h0000_0100;

  logic   clk, rst_n;
  word_t  imem_addr_o, dmem_addr_o, dmem_wdata_o, debug_pc_o, dmem_rdata_i;
  logic   imem_req_o, imem_ready_i, dmem_read_o, dmem_write_o, dmem_ready_i, debug_stall_o;
  instr_t imem_data_i;

  instr_t imem [IMEM_DEPTH];
  word_t  dmem [IMEM_DEPTH];
  instr_t prog [$];
  word_t  exp_addr [$];
  word_t  exp_data [$];
  word_t  obs_addr [$];
  word_t  obs_data [$];
  integer seed        = 37;
  int     store_off   = 0;

  tb_clk_gen tb_clk_gen_inst (.clk_o(clk), .rst_n_o(rst_n));

  rv_core_top rv_core_top_inst (
    .clk (clk), .rst_n (rst_n),
    .imem_addr_o (imem_addr_o), .imem_req_o (imem_req_o),
    .imem_data_i (imem_data_i), .imem_ready_i (imem_ready_i),
    .dmem_addr_o (dmem_addr_o), .dmem_wdata_o (dmem_wdata_o),
    .dmem_read_o (dmem_read_o), .dmem_write_o (dmem_write_o),
    .dmem_rdata_i (dmem_rdata_i), .dmem_ready_i (dmem_ready_i),
    .debug_pc_o (debug_pc_o), .debug_stall_o (debug_stall_o)
  );

  // ==========================================================================
  // Instruction encoders
  // ==========================================================================
  function automatic instr_t r_type(input logic [6:0] f7, input logic [2:0] f3,
                                    input reg_idx_t rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, OPC_OP};
  endfunction

  function automatic instr_t i_type(input logic [6:0] opc, input logic [2:0] f3,
                                    input reg_idx_t rd, rs1, input word_t imm);
    return {imm[11:0], rs1, f3, rd, opc};
  endfunction

  // sw rs2, imm(rs1)
  function automatic instr_t s_type(input reg_idx_t rs2, rs1, input word_t imm);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], OPC_STORE};
  endfunction

  function automatic instr_t b_type(input logic [2:0] f3, input reg_idx_t rs1, rs2,
                                    input word_t imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic instr_t u_type(input logic [6:0] opc, input reg_idx_t rd,
                                    input logic [19:0] imm);
    return {imm, rd, opc};
  endfunction

  function automatic instr_t j_type(input reg_idx_t rd, input word_t imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // ==========================================================================
  // Program building and checking
  // ==========================================================================
  task automatic emit(input instr_t ins);
    prog.push_back(ins);
  endtask

  // Result in x3 goes to the next slot of the store area
  task automatic store_result(input word_t expected);
    emit(s_type(5'd3, 5'd10, word_t'(store_off)));
    exp_addr.push_back(DMEM_BASE + word_t'(store_off));
    exp_data.push_back(expected);
    store_off += 4;
  endtask

  task automatic op_then_store(input instr_t ins, input word_t expected);
    emit(ins);
    store_result(expected);
  endtask

  task automatic report_failure(input string why);
    $display("%s", why);
    $display("=== FAIL ===");
    $fatal(1);
  endtask

  task automatic check_equal(input word_t got, input word_t expected, input string what);
    if (got !== expected) begin
      $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, what, got, expected);
      report_failure("Value check failed");
    end
  endtask

  task automatic wait_for_store();
    int cycles;
    cycles = 0;
    while (obs_addr.size() == 0) begin
      @(posedge clk);
      cycles++;
      if (cycles > STORE_TIMEOUT) begin
        report_failure("Timed out waiting for a store on the data port");
      end
    end
  endtask

  // Memory models, answered on the falling edge
  always @(negedge clk) begin
    // A data access that waited through the last half cycle shows as a stall
    if (rst_n === 1'b1 && (dmem_read_o || dmem_write_o) && !dmem_ready_i) begin
      check_equal(word_t'(debug_stall_o), 32'd1, "stall flag while data access waits");
    end
    if (rst_n !== 1'b1) begin
      imem_ready_i = 1'b0;
      dmem_ready_i = 1'b0;
    end else begin
      imem_ready_i = ($random(seed) & 3) != 0;
      dmem_ready_i = ($random(seed) & 1) != 0;
    end
    imem_data_i  = imem[imem_addr_o[9:2]];
    dmem_rdata_i = dmem[dmem_addr_o[9:2]];
    // Write completes on the coming rising edge
    if (dmem_ready_i && dmem_write_o) begin
      dmem[dmem_addr_o[9:2]] = dmem_wdata_o;
      obs_addr.push_back(dmem_addr_o);
      obs_data.push_back(dmem_wdata_o);
    end
  end

  always @(posedge clk) begin
    if (rv_core_top_inst.rv_core_chk_inst.fail_count != 0) begin
      report_failure("A bus protocol assertion failed");
    end
  end

  initial begin
    word_t  pc;
    instr_t stray;
    int     cycles;
    imem_ready_i = 1'b0;
    imem_data_i  = '0;
    dmem_ready_i = 1'b0;
    dmem_rdata_i = '0;
    stray        = s_type(5'd1, 5'd0, 32'h200);

    // x10 base, x1 = 100, x2 = -7, x4 = 3
    emit(i_type(OPC_OP_IMM, 3'b000, 5'd10, 5'd0, 32'd256));
    emit(i_type(OPC_OP_IMM, 3'b000, 5'd1, 5'd0, 32'd100));
    emit(i_type(OPC_OP_IMM, 3'b000, 5'd2, 5'd0, -32'sd7));
    emit(i_type(OPC_OP_IMM, 3'b000, 5'd4, 5'd0, 32'd3));
    op_then_store(r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd2), 32'd93);
    op_then_store(r_type(7'h20, 3'b000, 5'd3, 5'd1, 5'd2), 32'd107);
    op_then_store(r_type(7'h00, 3'b001, 5'd3, 5'd2, 5'd4), 32'hFFFF_FFC8);
    op_then_store(r_type(7'h00, 3'b010, 5'd3, 5'd2, 5'd1), 32'd1);
    op_then_store(r_type(7'h00, 3'b011, 5'd3, 5'd2, 5'd1), 32'd0);
    op_then_store(r_type(7'h00, 3'b100, 5'd3, 5'd1, 5'd2), 32'hFFFF_FF9D);
    op_then_store(r_type(7'h00, 3'b101, 5'd3, 5'd2, 5'd4), 32'h1FFF_FFFF);
    op_then_store(r_type(7'h20, 3'b101, 5'd3, 5'd2, 5'd4), 32'hFFFF_FFFF);
    op_then_store(r_type(7'h00, 3'b110, 5'd3, 5'd1, 5'd2), 32'hFFFF_FFFD);
    op_then_store(r_type(7'h00, 3'b111, 5'd3, 5'd1, 5'd2), 32'h0000_0060);
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd1, 32'd23), 32'd123);
    op_then_store(i_type(OPC_OP_IMM, 3'b010, 5'd3, 5'd2, -32'sd6), 32'd1);
    op_then_store(i_type(OPC_OP_IMM, 3'b011, 5'd3, 5'd2, 32'd5), 32'd0);
    op_then_store(i_type(OPC_OP_IMM, 3'b100, 5'd3, 5'd1, 32'hFF), 32'h9B);
    op_then_store(i_type(OPC_OP_IMM, 3'b110, 5'd3, 5'd1, 32'h0F), 32'h6F);
    op_then_store(i_type(OPC_OP_IMM, 3'b111, 5'd3, 5'd2, 32'hF0), 32'hF0);
    op_then_store(i_type(OPC_OP_IMM, 3'b001, 5'd3, 5'd1, 32'd4), 32'h640);
    op_then_store(i_type(OPC_OP_IMM, 3'b101, 5'd3, 5'd2, 32'd28), 32'hF);
    op_then_store(i_type(OPC_OP_IMM, 3'b101, 5'd3, 5'd2, 32'h401), 32'hFFFF_FFFC);
    op_then_store(u_type(OPC_LUI, 5'd3, 20'hABCDE), 32'hABCD_E000);
    op_then_store(u_type(OPC_AUIPC, 5'd3, 20'h1), word_t'(4 * prog.size()) + 32'h1000);

    // Dependent chain, each step waits for the previous write
    emit(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'd1));
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd3, 5'd3));
    emit(r_type(7'h00, 3'b000, 5'd3, 5'd3, 5'd3));
    op_then_store(i_type(OPC_OP_IMM, 3'b001, 5'd3, 5'd3, 32'd2), 32'd16);

    // Taken forms skip a stray store, not-taken forms fall into a checked one
    emit(b_type(3'b000, 5'd1, 5'd1, 32'd8));
    emit(stray);
    emit(b_type(3'b000, 5'd1, 5'd2, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h51), 32'h51);
    emit(b_type(3'b001, 5'd1, 5'd2, 32'd8));
    emit(stray);
    emit(b_type(3'b001, 5'd1, 5'd1, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h52), 32'h52);
    emit(b_type(3'b100, 5'd2, 5'd1, 32'd8));
    emit(stray);
    emit(b_type(3'b100, 5'd1, 5'd2, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h53), 32'h53);
    emit(b_type(3'b101, 5'd1, 5'd2, 32'd8));
    emit(stray);
    emit(b_type(3'b101, 5'd2, 5'd1, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h54), 32'h54);
    emit(b_type(3'b110, 5'd1, 5'd2, 32'd8));
    emit(stray);
    emit(b_type(3'b110, 5'd2, 5'd1, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h55), 32'h55);
    emit(b_type(3'b111, 5'd2, 5'd1, 32'd8));
    emit(stray);
    emit(b_type(3'b111, 5'd1, 5'd2, 32'd12));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd0, 32'h56), 32'h56);

    // JAL and JALR links
    pc = word_t'(4 * prog.size());
    emit(j_type(5'd3, 32'd8));
    emit(stray);
    store_result(pc + 32'd4);
    pc = word_t'(4 * prog.size());
    emit(u_type(OPC_AUIPC, 5'd5, 20'h0));
    emit(i_type(OPC_JALR, 3'b000, 5'd3, 5'd5, 32'd12));
    emit(stray);
    store_result(pc + 32'd8);

    // Loads of earlier stores, the second one used at once
    emit(i_type(OPC_LOAD, 3'b010, 5'd3, 5'd10, 32'd0));
    store_result(32'd93);
    emit(i_type(OPC_LOAD, 3'b010, 5'd3, 5'd10, 32'd4));
    op_then_store(i_type(OPC_OP_IMM, 3'b000, 5'd3, 5'd3, 32'd1), 32'd108);
    emit(j_type(5'd0, 32'd0));

    // Unused words are ADDI x0 with the word address as immediate
    for (int i = 0; i < IMEM_DEPTH; i++) begin
      imem[i] = i_type(OPC_OP_IMM, 3'b000, 5'd0, 5'd0, word_t'(i * 4));
      dmem[i] = 32'hA5A5_0000 ^ word_t'(i * 4);
    end
    foreach (prog[i]) begin
      imem[i] = prog[i];
    end

    // Reset and the first request
    @(posedge clk);
    cycles = 0;
    do begin
      @(negedge clk);
      check_equal(word_t'({dmem_read_o, dmem_write_o}), '0, "data strobes around reset");
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        report_failure("Reset was never released");
      end
    end while (!rst_n);
    check_equal(word_t'(imem_req_o), 32'd1, "instruction request after reset");
    check_equal(imem_addr_o, RESET_PC, "first instruction address");
    check_equal(debug_pc_o, RESET_PC, "program counter after reset");
    check_equal(word_t'(debug_stall_o), '0, "stall flag after reset");

    foreach (exp_addr[k]) begin
      wait_for_store();
      check_equal(obs_addr.pop_front(), exp_addr[k], $sformatf("address of store %0d", k));
      check_equal(obs_data.pop_front(), exp_data[k], $sformatf("data of store %0d", k));
    end

    // Core spins on its final JAL, nothing more may reach memory
    for (int c = 0; c < HALT_WINDOW; c++) begin
      @(posedge clk);
    end
    check_equal(word_t'(obs_addr.size()), '0, "stores after the final expected store");

    if (rv_core_top_inst.rv_core_chk_inst.fail_count == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      report_failure("A bus protocol assertion failed");
    end
  end

endmodule

`default_nettype wire

// ==== rv_core_chk.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_chk (
  input logic          clk,
  input logic          rst_n,
  input logic          imem_req_i,
  input rv_pkg::word_t imem_addr_i,
  input logic          imem_ready_i,
  input rv_pkg::word_t dmem_addr_i,
  input rv_pkg::word_t dmem_wdata_i,
  input logic          dmem_read_i,
  input logic          dmem_write_i,
  input logic          dmem_ready_i
);
  import rv_pkg::*;

  int unsigned fail_count = 0;

  a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    !(dmem_read_i && dmem_write_i))
    else begin
      $error("Data read and write strobes high in the same cycle");
      fail_count++;
    end

  // Access stays presented until the memory answers
  a_dmem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    (dmem_read_i || dmem_write_i) && !dmem_ready_i |=>
      $stable(dmem_addr_i) && $stable(dmem_wdata_i) &&
      $stable({dmem_read_i, dmem_write_i}))
    else begin
      $error("Data access changed while waiting for ready");
      fail_count++;
    end

  a_imem_hold: assert property (@(posedge clk) disable iff (!rst_n)
    imem_req_i && !imem_ready_i |=> imem_req_i && $stable(imem_addr_i))
    else begin
      $error("Instruction request changed while waiting for ready");
      fail_count++;
    end

  a_reset_quiet: assert property (@(posedge clk)
    $rose(rst_n) |-> !dmem_read_i && !dmem_write_i)
    else begin
      $error("Data strobe high in the first cycle after reset");
      fail_count++;
    end

endmodule

bind rv_core_top rv_core_chk rv_core_chk_inst (
  .clk          (clk),
  .rst_n        (rst_n),
  .imem_req_i   (imem_req_o),
  .imem_addr_i  (imem_addr_o),
  .imem_ready_i (imem_ready_i),
  .dmem_addr_i  (dmem_addr_o),
  .dmem_wdata_i (dmem_wdata_o),
  .dmem_read_i  (dmem_read_o),
  .dmem_write_i (dmem_write_o),
  .dmem_ready_i (dmem_ready_i)
);

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  // 4 ns period
  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Reset held for three rising edges, released after the third
  initial begin
    rst_n_o = 1'b0;
    repeat (3) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

`default_nettype wire

// ==== rv_core_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_core_top (
  input  logic           clk,
  input  logic           rst_n,
  output rv_pkg::word_t  imem_addr_o,
  output logic           imem_req_o,
  input  rv_pkg::instr_t imem_data_i,
  input  logic           imem_ready_i,
  output rv_pkg::word_t  dmem_addr_o,
  output rv_pkg::word_t  dmem_wdata_o,
  output logic           dmem_read_o,
  output logic           dmem_write_o,
  input  rv_pkg::word_t  dmem_rdata_i,
  input  logic           dmem_ready_i,
  output rv_pkg::word_t  debug_pc_o,
  output logic           debug_stall_o
);
  import rv_pkg::*;

  logic     if_valid;
  word_t    if_pc;
  instr_t   if_instr;
  reg_idx_t rs1, rs2;
  word_t    rs1_data, rs2_data;
  logic     wb_en;
  reg_idx_t wb_rd;
  word_t    wb_data;
  logic     redirect_valid;
  word_t    redirect_pc;
  logic     kill;
  logic     mem_wait;
  logic     hazard_stall;
  logic     pipe_stall;

  id_ex_if id_ex_bus ();

  // Either stall source holds fetch
  assign pipe_stall    = hazard_stall | mem_wait;
  assign debug_stall_o = pipe_stall;

  rv_fetch rv_fetch_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .redirect_valid_i (redirect_valid),
    .redirect_pc_i    (redirect_pc),
    .stall_i          (pipe_stall),
    .imem_addr_o      (imem_addr_o),
    .imem_req_o       (imem_req_o),
    .imem_data_i      (imem_data_i),
    .imem_ready_i     (imem_ready_i),
    .if_valid_o       (if_valid),
    .if_pc_o          (if_pc),
    .if_instr_o       (if_instr),
    .debug_pc_o       (debug_pc_o)
  );

  rv_regfile rv_regfile_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .rs1_i      (rs1),
    .rs2_i      (rs2),
    .rs1_data_o (rs1_data),
    .rs2_data_o (rs2_data),
    .wb_en_i    (wb_en),
    .wb_rd_i    (wb_rd),
    .wb_data_i  (wb_data)
  );

  rv_decode rv_decode_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .if_valid_i     (if_valid),
    .if_pc_i        (if_pc),
    .if_instr_i     (if_instr),
    .rs1_o          (rs1),
    .rs2_o          (rs2),
    .rs1_data_i     (rs1_data),
    .rs2_data_i     (rs2_data),
    .wb_en_i        (wb_en),
    .wb_rd_i        (wb_rd),
    .kill_i         (kill),
    .mem_wait_i     (mem_wait),
    .hazard_stall_o (hazard_stall),
    .ex             (id_ex_bus.decode_mp)
  );

  rv_execute rv_execute_inst (
    .clk              (clk),
    .rst_n            (rst_n),
    .ex               (id_ex_bus.execute_mp),
    .dmem_addr_o      (dmem_addr_o),
    .dmem_wdata_o     (dmem_wdata_o),
    .dmem_read_o      (dmem_read_o),
    .dmem_write_o     (dmem_write_o),
    .dmem_rdata_i     (dmem_rdata_i),
    .dmem_ready_i     (dmem_ready_i),
    .mem_wait_o       (mem_wait),
    .redirect_valid_o (redirect_valid),
    .redirect_pc_o    (redirect_pc),
    .kill_o           (kill),
    .wb_en_o          (wb_en),
    .wb_rd_o          (wb_rd),
    .wb_data_o        (wb_data)
  );

endmodule

`default_nettype wire

// ==== rv_execute.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_execute (
  input  logic             clk,
  input  logic             rst_n,
  id_ex_if.execute_mp      ex,
  output rv_pkg::word_t    dmem_addr_o,
  output rv_pkg::word_t    dmem_wdata_o,
  output logic             dmem_read_o,
  output logic             dmem_write_o,
  input  rv_pkg::word_t    dmem_rdata_i,
  input  logic             dmem_ready_i,
  output logic             mem_wait_o,
  output logic             redirect_valid_o,
  output rv_pkg::word_t    redirect_pc_o,
  output logic             kill_o,
  output logic             wb_en_o,
  output rv_pkg::reg_idx_t wb_rd_o,
  output rv_pkg::word_t    wb_data_o
);
  import rv_pkg::*;

  word_t    alu_res;
  word_t    result;
  logic     br_cond;
  logic     taken;
  logic     wb_en_q;
  reg_idx_t wb_rd_q;
  word_t    wb_data_q;

  // ========================================================================
  // ALU
  // ========================================================================
  always_comb begin
    case (ex.alu_op)
      ALU_ADD:  alu_res = ex.op_a + ex.op_b;
      ALU_SUB:  alu_res = ex.op_a - ex.op_b;
      ALU_SLL:  alu_res = ex.op_a << ex.op_b[4:0];
      ALU_SLT:  alu_res = word_t'($signed(ex.op_a) < $signed(ex.op_b));
      ALU_SLTU: alu_res = word_t'(ex.op_a < ex.op_b);
      ALU_XOR:  alu_res = ex.op_a ^ ex.op_b;
      ALU_SRL:  alu_res = ex.op_a >> ex.op_b[4:0];
      ALU_SRA:  alu_res = $signed(ex.op_a) >>> ex.op_b[4:0];
      ALU_OR:   alu_res = ex.op_a | ex.op_b;
      ALU_AND:  alu_res = ex.op_a & ex.op_b;
      default:  alu_res = ex.op_b;
    endcase
  end

  // Branch compare on the raw register operands
  always_comb begin
    case (ex.funct3)
      3'b000:  br_cond = ex.op_a == ex.op_b;
      3'b001:  br_cond = ex.op_a != ex.op_b;
      3'b100:  br_cond = $signed(ex.op_a) < $signed(ex.op_b);
      3'b101:  br_cond = $signed(ex.op_a) >= $signed(ex.op_b);
      3'b110:  br_cond = ex.op_a < ex.op_b;
      3'b111:  br_cond = ex.op_a >= ex.op_b;
      default: br_cond = 1'b0;
    endcase
  end

  assign taken            = ex.valid && (ex.jump || (ex.branch && br_cond));
  assign redirect_valid_o = taken;
  assign redirect_pc_o    = ex.target;
  assign kill_o           = taken;

  // ========================================================================
  // Data memory, held until ready
  // ========================================================================
  assign dmem_addr_o  = alu_res;
  assign dmem_wdata_o = ex.store_data;
  assign dmem_read_o  = ex.valid && ex.mem_read;
  assign dmem_write_o = ex.valid && ex.mem_write;
  assign mem_wait_o   = (dmem_read_o || dmem_write_o) && !dmem_ready_i;

  always_comb begin
    if (ex.jump) begin
      result = ex.pc + word_t'(4);
    end else if (ex.mem_read) begin
      result = dmem_rdata_i;
    end else begin
      result = alu_res;
    end
  end

  // EX/WB, empty while an access waits
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_en_q <= 1'b0;
    end else begin
      wb_en_q <= ex.valid && ex.reg_write && !mem_wait_o;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd_q   <= ex.rd;
    wb_data_q <= result;
  end

  assign wb_en_o   = wb_en_q;
  assign wb_rd_o   = wb_rd_q;
  assign wb_data_o = wb_data_q;

endmodule

`default_nettype wire

// ==== rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_decode (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             if_valid_i,
  input  rv_pkg::word_t    if_pc_i,
  input  rv_pkg::instr_t   if_instr_i,
  output rv_pkg::reg_idx_t rs1_o,
  output rv_pkg::reg_idx_t rs2_o,
  input  rv_pkg::word_t    rs1_data_i,
  input  rv_pkg::word_t    rs2_data_i,
  input  logic             wb_en_i,
  input  rv_pkg::reg_idx_t wb_rd_i,
  input  logic             kill_i,
  input  logic             mem_wait_i,
  output logic             hazard_stall_o,
  id_ex_if.decode_mp       ex
);
  import rv_pkg::*;

  function automatic alu_op_e alu_from_funct(input logic [2:0] f3, input logic alt);
    alu_op_e op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  instr_t     instr;
  logic [6:0] opcode;
  logic [2:0] funct3;
  word_t      imm_i, imm_s, imm_b, imm_u, imm_j;
  logic       known, use_rs1, use_rs2;
  logic       d_reg_write, d_mem_read, d_mem_write, d_branch, d_jump;
  alu_op_e    d_alu_op;
  word_t      d_op_a, d_op_b, d_target;
  logic       rs1_busy, rs2_busy, issue;

  // Empty slot decodes as a NOP so its register fields read x0
  assign instr  = if_valid_i ? if_instr_i : NOP_INSTR;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign rs1_o  = instr[19:15];
  assign rs2_o  = instr[24:20];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'b0};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  // ========================================================================
  // Control and operand selection
  // ========================================================================
  always_comb begin
    known       = 1'b1;
    use_rs1     = 1'b0;
    use_rs2     = 1'b0;
    d_reg_write = 1'b0;
    d_mem_read  = 1'b0;
    d_mem_write = 1'b0;
    d_branch    = 1'b0;
    d_jump      = 1'b0;
    d_alu_op    = ALU_ADD;
    d_op_a      = rs1_data_i;
    d_op_b      = rs2_data_i;
    d_target    = if_pc_i + imm_b;
    case (opcode)
      OPC_OP: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        d_reg_write = 1'b1;
        d_alu_op    = alu_from_funct(funct3, instr[30]);
      end
      OPC_OP_IMM: begin
        use_rs1     = 1'b1;
        d_reg_write = 1'b1;
        d_op_b      = imm_i;
        // Only SRAI carries the alternate bit
        d_alu_op    = alu_from_funct(funct3, instr[30] && (funct3 == 3'b101));
      end
      OPC_LUI: begin
        d_reg_write = 1'b1;
        d_op_b      = imm_u;
        d_alu_op    = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        d_reg_write = 1'b1;
        d_op_a      = if_pc_i;
        d_op_b      = imm_u;
      end
      OPC_BRANCH: begin
        use_rs1  = 1'b1;
        use_rs2  = 1'b1;
        d_branch = 1'b1;
      end
      OPC_JAL: begin
        d_reg_write = 1'b1;
        d_jump      = 1'b1;
        d_target    = if_pc_i + imm_j;
      end
      OPC_JALR: begin
        use_rs1     = 1'b1;
        d_reg_write = 1'b1;
        d_jump      = 1'b1;
        d_target    = (rs1_data_i + imm_i) & ~word_t'(1);
      end
      OPC_LOAD: begin
        use_rs1     = 1'b1;
        d_reg_write = 1'b1;
        d_mem_read  = 1'b1;
        d_op_b      = imm_i;
      end
      OPC_STORE: begin
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
        d_mem_write = 1'b1;
        d_op_b      = imm_s;
      end
      default: known = 1'b0;
    endcase
  end

  // ========================================================================
  // Interlock against pending writes in execute and write-back
  // ========================================================================
  assign rs1_busy = (rs1_o != '0) &&
                    ((ex.valid && ex.reg_write && (ex.rd == rs1_o)) ||
                     (wb_en_i && (wb_rd_i == rs1_o)));
  assign rs2_busy = (rs2_o != '0) &&
                    ((ex.valid && ex.reg_write && (ex.rd == rs2_o)) ||
                     (wb_en_i && (wb_rd_i == rs2_o)));

  assign hazard_stall_o = if_valid_i && ((use_rs1 && rs1_busy) || (use_rs2 && rs2_busy));
  assign issue          = if_valid_i && known && !hazard_stall_o && !kill_i;

  // ID/EX control, a bubble when nothing issues
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex.valid     <= 1'b0;
      ex.reg_write <= 1'b0;
      ex.mem_read  <= 1'b0;
      ex.mem_write <= 1'b0;
      ex.branch    <= 1'b0;
      ex.jump      <= 1'b0;
    end else if (!mem_wait_i) begin
      ex.valid     <= issue;
      ex.reg_write <= issue && d_reg_write;
      ex.mem_read  <= issue && d_mem_read;
      ex.mem_write <= issue && d_mem_write;
      ex.branch    <= issue && d_branch;
      ex.jump      <= issue && d_jump;
    end
  end

  always_ff @(posedge clk) begin
    if (!mem_wait_i) begin
      ex.pc         <= if_pc_i;
      ex.alu_op     <= d_alu_op;
      ex.op_a       <= d_op_a;
      ex.op_b       <= d_op_b;
      ex.store_data <= rs2_data_i;
      ex.rd         <= instr[11:7];
      ex.funct3     <= funct3;
      ex.target     <= d_target;
    end
  end

endmodule

`default_nettype wire

// ==== rv_regfile.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_regfile (
  input  logic             clk,
  input  logic             rst_n,
  input  rv_pkg::reg_idx_t rs1_i,
  input  rv_pkg::reg_idx_t rs2_i,
  output rv_pkg::word_t    rs1_data_o,
  output rv_pkg::word_t    rs2_data_o,
  input  logic             wb_en_i,
  input  rv_pkg::reg_idx_t wb_rd_i,
  input  rv_pkg::word_t    wb_data_i
);
  import rv_pkg::*;

  word_t regs [REG_COUNT];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_en_i && (wb_rd_i != '0)) begin
      regs[wb_rd_i] <= wb_data_i;
    end
  end

  // x0 always reads as zero
  assign rs1_data_o = (rs1_i == '0) ? '0 : regs[rs1_i];
  assign rs2_data_o = (rs2_i == '0) ? '0 : regs[rs2_i];

endmodule

`default_nettype wire

// ==== rv_fetch.sv ====
`timescale 1ns/1ns
`default_nettype none

module rv_fetch (
  input  logic           clk,
  input  logic           rst_n,
  input  logic           redirect_valid_i,
  input  rv_pkg::word_t  redirect_pc_i,
  input  logic           stall_i,
  output rv_pkg::word_t  imem_addr_o,
  output logic           imem_req_o,
  input  rv_pkg::instr_t imem_data_i,
  input  logic           imem_ready_i,
  output logic           if_valid_o,
  output rv_pkg::word_t  if_pc_o,
  output rv_pkg::instr_t if_instr_o,
  output rv_pkg::word_t  debug_pc_o
);
  import rv_pkg::*;

  word_t  pc_q;
  word_t  redir_pc_q;
  logic   redir_pend_q;
  logic   if_valid_q;
  word_t  if_pc_q;
  instr_t if_instr_q;
  logic   hold_valid_q;
  word_t  hold_pc_q;
  instr_t hold_instr_q;
  logic   take;
  logic   req_open;

  // No new request while a fetched word sits in the hold slot
  assign imem_req_o  = !hold_valid_q;
  assign imem_addr_o = pc_q;
  assign take        = imem_req_o && imem_ready_i;
  assign req_open    = imem_req_o && !imem_ready_i;

  // ========================================================================
  // PC and valid bits
  // ========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q         <= RESET_PC;
      redir_pend_q <= 1'b0;
      if_valid_q   <= 1'b0;
      hold_valid_q <= 1'b0;
    end else if (redirect_valid_i) begin
      if_valid_q   <= 1'b0;
      hold_valid_q <= 1'b0;
      // Unanswered request keeps its address, the answer gets dropped
      redir_pend_q <= req_open;
      if (!req_open) begin
        pc_q <= redirect_pc_i;
      end
    end else if (redir_pend_q) begin
      if (imem_ready_i) begin
        pc_q         <= redir_pc_q;
        redir_pend_q <= 1'b0;
      end
    end else begin
      if (!stall_i) begin
        if_valid_q   <= hold_valid_q || take;
        hold_valid_q <= 1'b0;
      end else if (take && if_valid_q) begin
        hold_valid_q <= 1'b1;
      end else if (take) begin
        if_valid_q <= 1'b1;
      end
      if (take) begin
        pc_q <= pc_q + word_t'(4);
      end
    end
  end

  // Payload, qualified by the valid bits above
  always_ff @(posedge clk) begin
    if (redirect_valid_i) begin
      redir_pc_q <= redirect_pc_i;
    end
    if (!stall_i && hold_valid_q) begin
      if_pc_q    <= hold_pc_q;
      if_instr_q <= hold_instr_q;
    end else if (take && (!stall_i || !if_valid_q)) begin
      if_pc_q    <= pc_q;
      if_instr_q <= imem_data_i;
    end
    if (take && stall_i && if_valid_q) begin
      hold_pc_q    <= pc_q;
      hold_instr_q <= imem_data_i;
    end
  end

  assign if_valid_o = if_valid_q;
  assign if_pc_o    = if_pc_q;
  assign if_instr_o = if_instr_q;
  assign debug_pc_o = pc_q;

endmodule

`default_nettype wire

// ==== id_ex_if.sv ====
`timescale 1ns/1ns
`default_nettype none

interface id_ex_if;
  import rv_pkg::*;

  logic       valid;
  word_t      pc;
  alu_op_e    alu_op;
  word_t      op_a;
  word_t      op_b;
  word_t      store_data;
  reg_idx_t   rd;
  logic       reg_write;
  logic       mem_read;
  logic       mem_write;
  logic       branch;
  logic [2:0] funct3;
  logic       jump;
  // PC + imm, or rs1 + imm for JALR
  word_t      target;

  modport decode_mp (
    output valid, pc, alu_op, op_a, op_b, store_data, rd,
    output reg_write, mem_read, mem_write, branch, funct3, jump, target
  );

  modport execute_mp (
    input valid, pc, alu_op, op_a, op_b, store_data, rd,
    input reg_write, mem_read, mem_write, branch, funct3, jump, target
  );

endinterface

`default_nettype wire

// ==== rv_pkg.sv ====
`default_nettype none

package rv_pkg;

  // ========================================================================
  // Widths and machine constants
  // ========================================================================
  localparam int XLEN      = 32;
  localparam int REG_COUNT = 32;

  typedef logic [XLEN-1:0] word_t;
  typedef logic [4:0]      reg_idx_t;
  typedef logic [31:0]     instr_t;

  localparam word_t  RESET_PC  = 32'h0000_0000;
  // ADDI x0, x0, 0
  localparam instr_t NOP_INSTR = 32'h0000_0013;

  // ========================================================================
  // Major opcodes
  // ========================================================================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;

  // ALU operations, PASS_B forwards operand b for LUI
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B
  } alu_op_e;

endpackage

`default_nettype wire
